// ==== bench/tb_data_cache.sv ====
// ====================
// Data cache testbench
// ====================
`default_nettype none

`include "cache_macros.svh"

module tb_data_cache import cache_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        cpu_req;
    logic        cpu_we;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    mem_size_t   cpu_size;
    logic [31:0] cpu_rdata;
    logic        cpu_stall;

    logic [7:0] ref_mem [`MEM_WORDS*4];    // Byte model of the 4 KiB memory

    data_cache dut_i (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_size  (cpu_size),
        .cpu_rdata (cpu_rdata),
        .cpu_stall (cpu_stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("ERROR t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] expected_load(input logic [31:0] addr, input mem_size_t size);
        logic [11:0] a;
        logic [11:0] base;
        logic [7:0]  b;
        logic [15:0] h;
        a    = addr[11:0];
        base = {a[11:2], 2'b00};
        b    = ref_mem[a];
        h    = {ref_mem[a + 12'd1], ref_mem[a]};    // Little endian
        case (size)
            BYTE:    return {{24{b[7]}}, b};
            HALF:    return {{16{h[15]}}, h};
            BYTE_U:  return {24'd0, b};
            HALF_U:  return {16'd0, h};
            default: return {ref_mem[base + 12'd3], ref_mem[base + 12'd2],
                             ref_mem[base + 12'd1], ref_mem[base]};
        endcase
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input mem_size_t size);
        logic [11:0] a;
        a = addr[11:0];
        case (size)
            BYTE: ref_mem[a] = data[7:0];
            HALF: begin
                ref_mem[a]         = data[7:0];
                ref_mem[a + 12'd1] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[{a[11:2], 2'b00} + 12'(i)] = data[8*i +: 8];
                end
            end
        endcase
    endtask

    // One CPU request, held until the stall drops
    task automatic cpu_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, input mem_size_t size,
                              output int stalls);
        stalls = 0;
        @(negedge clk);
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_size  = size;
        #5;    // Outputs settle in the low phase
        while (cpu_stall) begin
            check_value("cpu_rdata", cpu_rdata, 32'd0);
            stalls++;
            if (stalls > 20) begin
                abort_run("Request still stalled after 20 cycles");
            end
            @(negedge clk);
            #5;
        end
        if (we) begin
            check_value("cpu_rdata", cpu_rdata, 32'd0);    // No data on a store
            model_write(addr, wdata, size);
        end else begin
            check_value("cpu_rdata", cpu_rdata, expected_load(addr, size));
        end
        @(negedge clk);
        cpu_req = 1'b0;
    endtask

    task automatic word_store_load_test();
        logic [31:0] addrs [8];
        int          st;
        for (int i = 0; i < 8; i++) begin
            addrs[i]    = $urandom_range(1023) << 2;
            addrs[i][6] = 1'b0;    // Sets 0 to 3, upper sets kept for timing tests
            cpu_access(1'b1, addrs[i], $urandom, WORD, st);
        end
        for (int i = 0; i < 8; i++) begin
            cpu_access(1'b0, addrs[i], 32'd0, WORD, st);
        end
    endtask

    task automatic subword_load_test();
        logic [31:0] addr;
        logic [31:0] data;
        int          st;
        addr = 32'h0000_0230;
        // Bytes 0 and 3 negative, bytes 1 and 2 positive
        data = ($urandom & 32'hFF7F_7FFF) | 32'h8000_0080;
        cpu_access(1'b1, addr, data, WORD, st);
        for (int off = 0; off < 4; off++) begin
            cpu_access(1'b0, addr + off, 32'd0, BYTE, st);
            cpu_access(1'b0, addr + off, 32'd0, BYTE_U, st);
        end
        for (int off = 0; off < 4; off += 2) begin
            cpu_access(1'b0, addr + off, 32'd0, HALF, st);
            cpu_access(1'b0, addr + off, 32'd0, HALF_U, st);
        end
    endtask

    task automatic subword_store_test();
        logic [31:0] addr;
        int          st;
        addr = 32'h0000_0328;
        cpu_access(1'b1, addr, $urandom, WORD, st);
        for (int off = 0; off < 4; off++) begin
            cpu_access(1'b1, addr + off, $urandom, BYTE, st);
            cpu_access(1'b0, addr, 32'd0, WORD, st);
        end
        for (int off = 0; off < 4; off += 2) begin
            cpu_access(1'b1, addr + off, $urandom, HALF, st);
            cpu_access(1'b0, addr, 32'd0, WORD, st);
        end
    endtask

    task automatic miss_timing_test();
        int st;
        cpu_access(1'b0, 32'h0000_0040, 32'd0, WORD, st);    // Untouched set 4
        check_value("clean miss stall cycles", st, 32'd6);
        cpu_access(1'b0, 32'h0000_0040, 32'd0, WORD, st);
        check_value("hit stall cycles", st, 32'd0);
    endtask

    // Tags A, B and C all map to set 5
    task automatic eviction_lru_test();
        int st;
        cpu_access(1'b1, 32'h0000_00D0, $urandom, WORD, st);
        cpu_access(1'b1, 32'h0000_0150, $urandom, WORD, st);
        cpu_access(1'b0, 32'h0000_00D0, 32'd0, WORD, st);    // Touch A, B becomes LRU
        cpu_access(1'b0, 32'h0000_01D0, 32'd0, WORD, st);
        check_value("dirty miss stall cycles", st, 32'd10);
        cpu_access(1'b0, 32'h0000_00D0, 32'd0, WORD, st);
        check_value("kept line stall cycles", st, 32'd0);
        cpu_access(1'b0, 32'h0000_0150, 32'd0, WORD, st);    // Data from write-back
        check_value("refetch stall cycles", st, 32'd6);
    endtask

    initial begin
        void'($urandom(74));
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = 32'd0;
        cpu_wdata = 32'd0;
        cpu_size  = WORD;
        for (int i = 0; i < `MEM_WORDS*4; i++) begin
            ref_mem[i] = 8'd0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #5;
        check_value("cpu_stall", cpu_stall, 32'd0);

        word_store_load_test();
        subword_load_test();
        subword_store_test();
        miss_timing_test();
        eviction_lru_test();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cache/cache_ctrl.sv ====
// ====================
// Cache miss FSM
// ====================
`default_nettype none

`include "cache_macros.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cpu_req,
    input  logic                      cpu_we,
    input  logic                      hit,
    input  logic                      hit_way,      // LRU way on a miss
    input  index_t                    index,
    input  tag_t                      tag,
    input  logic                      victim_valid_dirty,
    input  tag_t                      victim_tag,
    input  logic [31:0]               victim_word,
    output logic                      cpu_stall,
    output logic                      hit_wr,
    output logic                      fill_wr,
    output logic                      fill_last,
    output logic                      victim_way,
    output beat_t                     beat,
    output logic [`MEM_ADDR_BITS-1:0] mem_addr,
    output logic [31:0]               mem_wdata,
    output logic                      mem_we
);

    // Tag bits that still reach the 4 KiB memory
    localparam int TAG_LO_BITS = `MEM_ADDR_BITS - `SET_BITS - 2;

    cache_state_t state_q;
    cache_state_t state_d;
    beat_t        beat_q;
    logic         victim_q;
    logic         line_xfer;

    assign line_xfer = (state_q == WRITEBACK) || (state_q == REFILL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= IDLE;
            beat_q   <= '0;
            victim_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (line_xfer) begin
                beat_q <= beat_q + 2'd1;    // Wraps to 0 after beat 3
            end else begin
                beat_q <= '0;
            end
            if (state_q == MISS_SELECT) begin
                victim_q <= hit_way;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cpu_req && !hit) begin
                    state_d = MISS_SELECT;
                end
            end
            MISS_SELECT: begin
                // Dirty victim goes back to memory first
                state_d = victim_valid_dirty ? WRITEBACK : REFILL;
            end
            WRITEBACK: begin
                if (beat_q == 2'd3) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (beat_q == 2'd3) begin
                    state_d = IDLE;    // Held request then hits
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign cpu_stall  = (state_q != IDLE) || (cpu_req && !hit);
    assign hit_wr     = (state_q == IDLE) && cpu_req && hit && cpu_we;
    assign fill_wr    = (state_q == REFILL);
    assign fill_last  = fill_wr && (beat_q == 2'd3);
    assign victim_way = line_xfer ? victim_q : hit_way;
    assign beat       = beat_q;

    // Memory word address and data per beat
    always_comb begin
        mem_addr  = '0;
        mem_wdata = 32'd0;
        mem_we    = 1'b0;
        case (state_q)
            WRITEBACK: begin
                mem_addr  = {victim_tag[TAG_LO_BITS-1:0], index, beat_q};
                mem_wdata = victim_word;
                mem_we    = 1'b1;
            end
            REFILL: begin
                mem_addr = {tag[TAG_LO_BITS-1:0], index, beat_q};
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== cache/cache_store.sv ====
// ====================
// Cache arrays
// ====================
`default_nettype none

`include "cache_macros.svh"

module cache_store import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  index_t      index,
    input  tag_t        tag,
    input  beat_t       word_sel,
    input  logic        hit_wr,
    input  logic [31:0] store_word,
    input  logic        fill_wr,
    input  logic        fill_last,
    input  logic        victim_way,
    input  beat_t       beat,
    input  logic [31:0] fill_word,
    output logic        hit,
    output logic        hit_way,
    output logic [31:0] hit_word,
    output logic        victim_valid_dirty,
    output tag_t        victim_tag,
    output logic [31:0] victim_word
);

    // Line state, indexed [way][set]
    logic [1:0][`CACHE_SETS-1:0] valid_q;
    logic [1:0][`CACHE_SETS-1:0] dirty_q;
    logic [`CACHE_SETS-1:0]      lru_q;      // Way to replace next

    tag_t        tag_q  [2][`CACHE_SETS];
    logic [31:0] data_q [2][`CACHE_SETS][`LINE_WORDS];

    logic hit0;
    logic hit1;

    assign hit0 = valid_q[0][index] && (tag_q[0][index] == tag);
    assign hit1 = valid_q[1][index] && (tag_q[1][index] == tag);
    assign hit  = hit0 || hit1;

    // On a miss the way output carries the LRU choice
    assign hit_way  = hit ? hit1 : lru_q[index];
    assign hit_word = data_q[hit1][index][word_sel];

    assign victim_valid_dirty = valid_q[victim_way][index] && dirty_q[victim_way][index];
    assign victim_tag         = tag_q[victim_way][index];
    assign victim_word        = data_q[victim_way][index][beat];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (fill_last) begin
                valid_q[victim_way][index] <= 1'b1;
                dirty_q[victim_way][index] <= 1'b0;    // Fresh line is clean
                lru_q[index]               <= ~victim_way;
            end else if (hit) begin
                lru_q[index] <= ~hit_way;
            end
            if (hit_wr) begin
                dirty_q[hit_way][index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit_wr) begin
            data_q[hit_way][index][word_sel] <= store_word;
        end
        if (fill_wr) begin
            data_q[victim_way][index][beat] <= fill_word;
        end
        // Tag written with the last refill word
        if (fill_last) begin
            tag_q[victim_way][index] <= tag;
        end
    end

endmodule

`default_nettype wire

// ==== cache/data_cache.sv ====
// ====================
// Data cache top
// ====================
`default_nettype none

`include "cache_macros.svh"

module data_cache import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_req,
    input  logic        cpu_we,
    input  logic [31:0] cpu_addr,
    input  logic [31:0] cpu_wdata,
    input  mem_size_t   cpu_size,
    output logic [31:0] cpu_rdata,
    output logic        cpu_stall
);

    // Address fields: tag | index | word | byte
    tag_t        req_tag;
    index_t      req_index;
    beat_t       req_word;
    logic [1:0]  req_byte;

    assign req_tag   = cpu_addr[31 -: `TAG_BITS];
    assign req_index = cpu_addr[`OFFSET_BITS +: `SET_BITS];
    assign req_word  = cpu_addr[`OFFSET_BITS-1:2];
    assign req_byte  = cpu_addr[1:0];

    logic        hit;
    logic        hit_way;
    logic [31:0] hit_word;
    logic        victim_valid_dirty;
    tag_t        victim_tag;
    logic [31:0] victim_word;
    logic [31:0] load_word;
    logic [31:0] store_word;
    logic        hit_wr;
    logic        fill_wr;
    logic        fill_last;
    logic        victim_way;
    beat_t       beat;

    logic [`MEM_ADDR_BITS-1:0] mem_addr;
    logic [31:0]               mem_wdata;
    logic                      mem_we;
    logic [31:0]               mem_rdata;

    // Load data only in the completing cycle of a load
    assign cpu_rdata = (cpu_req && !cpu_stall && !cpu_we) ? load_word : 32'd0;

    cache_ctrl u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .cpu_req            (cpu_req),
        .cpu_we             (cpu_we),
        .hit                (hit),
        .hit_way            (hit_way),
        .index              (req_index),
        .tag                (req_tag),
        .victim_valid_dirty (victim_valid_dirty),
        .victim_tag         (victim_tag),
        .victim_word        (victim_word),
        .cpu_stall          (cpu_stall),
        .hit_wr             (hit_wr),
        .fill_wr            (fill_wr),
        .fill_last          (fill_last),
        .victim_way         (victim_way),
        .beat               (beat),
        .mem_addr           (mem_addr),
        .mem_wdata          (mem_wdata),
        .mem_we             (mem_we)
    );

    cache_store u_store (
        .clk                (clk),
        .rst                (rst),
        .index              (req_index),
        .tag                (req_tag),
        .word_sel           (req_word),
        .hit_wr             (hit_wr),
        .store_word         (store_word),
        .fill_wr            (fill_wr),
        .fill_last          (fill_last),
        .victim_way         (victim_way),
        .beat               (beat),
        .fill_word          (mem_rdata),
        .hit                (hit),
        .hit_way            (hit_way),
        .hit_word           (hit_word),
        .victim_valid_dirty (victim_valid_dirty),
        .victim_tag         (victim_tag),
        .victim_word        (victim_word)
    );

    access_align u_align (
        .hit_word   (hit_word),
        .cpu_wdata  (cpu_wdata),
        .cpu_size   (cpu_size),
        .byte_sel   (req_byte),
        .load_word  (load_word),
        .store_word (store_word)
    );

    main_mem u_mem (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== common/cache_macros.svh ====
// ====================
// Cache geometry
// ====================
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Two-way cache, 8 sets of 16-byte lines
`define CACHE_SETS     8
`define SET_BITS       3
`define LINE_WORDS     4
`define OFFSET_BITS    4
`define TAG_BITS       25    // 32 - SET_BITS - OFFSET_BITS

// Backing store, 4 KiB of words
`define MEM_WORDS      1024
`define MEM_ADDR_BITS  10

`endif

// ==== common/cache_pkg.sv ====
// ====================
// Cache shared types
// ====================
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    // Miss handling sequence
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        MISS_SELECT = 3'd1,
        WRITEBACK   = 3'd2,
        REFILL      = 3'd3
    } cache_state_t;

    // RISC-V funct3 access codes, stores use the first three
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        BYTE_U = 3'b100,
        HALF_U = 3'b101
    } mem_size_t;

    typedef logic [`TAG_BITS-1:0] tag_t;
    typedef logic [`SET_BITS-1:0] index_t;
    typedef logic [1:0]           beat_t;    // Word within a line

endpackage

`default_nettype wire

// ==== hdl/access_align.sv ====
// ====================
// Load/store aligner
// ====================
`default_nettype none

`include "cache_macros.svh"

module access_align import cache_pkg::*; (
    input  logic [31:0] hit_word,
    input  logic [31:0] cpu_wdata,
    input  mem_size_t   cpu_size,
    input  logic [1:0]  byte_sel,
    output logic [31:0] load_word,
    output logic [31:0] store_word
);

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign ld_byte = hit_word[{byte_sel, 3'b000} +: 8];
    assign ld_half = hit_word[{byte_sel[1], 4'b0000} +: 16];

    // Load extension
    always_comb begin
        case (cpu_size)
            BYTE:    load_word = {{24{ld_byte[7]}}, ld_byte};
            HALF:    load_word = {{16{ld_half[15]}}, ld_half};
            BYTE_U:  load_word = {24'd0, ld_byte};
            HALF_U:  load_word = {16'd0, ld_half};
            default: load_word = hit_word;    // LW and unknown codes
        endcase
    end

    // Store merge into the old word
    always_comb begin
        store_word = hit_word;
        case (cpu_size)
            BYTE: begin
                store_word[{byte_sel, 3'b000} +: 8] = cpu_wdata[7:0];
            end
            HALF: begin
                store_word[{byte_sel[1], 4'b0000} +: 16] = cpu_wdata[15:0];
            end
            default: store_word = cpu_wdata;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/main_mem.sv ====
// ====================
// Backing memory
// ====================
`default_nettype none

`include "cache_macros.svh"

module main_mem (
    input  logic                      clk,
    input  logic [`MEM_ADDR_BITS-1:0] addr,    // Word address
    input  logic [31:0]               wdata,
    input  logic                      we,
    output logic [31:0]               rdata
);

    logic [31:0] mem_q [`MEM_WORDS];

    // Memory starts out all zero
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem_q[i] = 32'd0;
        end
    end

    assign rdata = mem_q[addr];

    always_ff @(posedge clk) begin
        if (we) begin
            mem_q[addr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_data_cache -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_data_cache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** PASSED ***"; then
    exit 0
fi
echo "Pass message not found"
exit 1

// ==== src.f ====
+incdir+common
common/cache_pkg.sv
hdl/access_align.sv
hdl/main_mem.sv
cache/cache_store.sv
cache/cache_ctrl.sv
cache/data_cache.sv
bench/tb_data_cache.sv
